//--- design/block_scheduler.sv
////////////////////
// Walks filters and tiles, one 11-step block per tile
// Drives both memory addresses and the step info for the tile window
////////////////////
module block_scheduler
    import cnn_feed_pkg::*;
#(
    parameter int TILE_ROWS   = 2,
    parameter int TILE_COLS   = 2,
    parameter int NUM_FILTERS = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    output logic [IMG_ADDR_W-1:0]  image_addr,
    output logic [CONV_ADDR_W-1:0] conv_addr,
    output logic [3:0]             step,
    output logic [1:0]             quad_slot,
    output logic                   block_active,
    output logic                   busy
);

    localparam int ROW_W = (TILE_ROWS > 1) ? $clog2(TILE_ROWS) : 1;
    localparam int COL_W = (TILE_COLS > 1) ? $clog2(TILE_COLS) : 1;
    localparam int FLT_W = (NUM_FILTERS > 1) ? $clog2(NUM_FILTERS) : 1;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DRAIN} state_t;

    state_t           state;
    logic [ROW_W-1:0] tile_row;
    logic [COL_W-1:0] tile_col;
    logic [FLT_W-1:0] filter;
    logic             last_col, last_row, last_filter;
    logic             block_done;

    logic [IMG_ADDR_W-1:0] quad_row, quad_col;

    assign last_col    = (tile_col == COL_W'(TILE_COLS - 1));
    assign last_row    = (tile_row == ROW_W'(TILE_ROWS - 1));
    assign last_filter = (filter == FLT_W'(NUM_FILTERS - 1));
    assign block_done  = (step == 4'(STEPS_PER_BLOCK - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            step     <= '0;
            tile_row <= '0;
            tile_col <= '0;
            filter   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_RUN;
                        step     <= '0;
                        tile_row <= '0;
                        tile_col <= '0;
                        filter   <= '0;
                    end
                end
                S_RUN: begin
                    step <= step + 4'd1;
                    if (block_done) begin
                        step     <= '0;
                        tile_col <= last_col ? '0 : tile_col + 1'b1;
                        if (last_col) begin
                            tile_row <= last_row ? '0 : tile_row + 1'b1;
                            if (last_row) begin
                                filter <= last_filter ? '0 : filter + 1'b1;
                                if (last_filter)
                                    state <= S_DRAIN; // Final SSFR still in flight
                            end
                        end
                    end
                end
                S_DRAIN: begin
                    // Two cycles until the last beat leaves the feed register
                    step <= step + 4'd1;
                    if (step == 4'd1) begin
                        step  <= '0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign busy         = (state != S_IDLE);
    assign block_active = (state == S_RUN);
    assign quad_slot    = step[1:0]; // Only meaningful in steps 0 to 3

    // Quad q of the tile sits at row 2*tr + q/2, column 2*tc + q%2
    assign quad_row   = IMG_ADDR_W'({tile_row, quad_slot[1]});
    assign quad_col   = IMG_ADDR_W'({tile_col, quad_slot[0]});
    assign image_addr = quad_row * IMG_ADDR_W'(2 * TILE_COLS) + quad_col;

    assign conv_addr = CONV_ADDR_W'(filter) * CONV_ADDR_W'(PARAMS_PER_FILTER)
                     + CONV_ADDR_W'(step);

endmodule

//--- design/cnn_feed_pkg.sv
////////////////////
// Shared types and fixed constants of the feed protocol
// Import into any module that handles pixels, quads or feed beats
////////////////////
package cnn_feed_pkg;

    // Memory address widths
    localparam int IMG_ADDR_W  = 10;
    localparam int CONV_ADDR_W = 15;
    localparam int RES_ADDR_W  = 14;

    localparam int TAPS              = 9;  // 3x3 kernel
    localparam int PARAMS_PER_FILTER = 10; // Bias first, then the weights
    localparam int STEPS_PER_BLOCK   = 11;

    typedef logic [7:0] pixel_t;

    // Pooling and ReLU instruction for the SSFR unit
    localparam pixel_t SSFR_OP  = 8'hC1;
    localparam pixel_t SSFR_ARG = 8'h28;

    // 2x2 group, lane n is row n/2, column n%2
    typedef struct packed {
        pixel_t lane0;
        pixel_t lane1;
        pixel_t lane2;
        pixel_t lane3;
    } quad_t;

    typedef enum logic [1:0] {
        BEAT_HEADER = 2'd0,
        BEAT_PATCH  = 2'd1,
        BEAT_SSFR   = 2'd2
    } beat_kind_t;

    typedef struct packed {
        logic       valid;
        beat_kind_t kind;
        logic [3:0] step;  // 0 to 10 inside a block
        quad_t      lanes;
        pixel_t     param; // Bias, weight or SSFR argument
    } feed_beat_t;

endpackage

//--- design/conv_feeder_top.sv
////////////////////
// Feed sequencer top for the first conv layer
// Set the tile grid and filter count here
////////////////////
module conv_feeder_top
    import cnn_feed_pkg::*;
#(
    parameter int TILE_ROWS   = 6,
    parameter int TILE_COLS   = 6,
    parameter int NUM_FILTERS = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    output logic [IMG_ADDR_W-1:0]  image_addr,
    input  quad_t                  image_quad,
    output logic [CONV_ADDR_W-1:0] conv_addr,
    input  pixel_t                 conv_data,
    input  logic                   result_valid,
    input  pixel_t                 result_data,
    input  logic [RES_ADDR_W-1:0]  res_rd_addr,
    output quad_t                  res_rd_data,
    output feed_beat_t             feed,
    output logic                   busy
);

    logic [3:0] step;
    logic [1:0] quad_slot;
    logic       block_active;

    block_scheduler #(
        .TILE_ROWS   (TILE_ROWS),
        .TILE_COLS   (TILE_COLS),
        .NUM_FILTERS (NUM_FILTERS)
    ) u_sched (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .image_addr   (image_addr),
        .conv_addr    (conv_addr),
        .step         (step),
        .quad_slot    (quad_slot),
        .block_active (block_active),
        .busy         (busy)
    );

    tile_window u_window (
        .clk          (clk),
        .reset        (reset),
        .step         (step),
        .quad_slot    (quad_slot),
        .block_active (block_active),
        .image_quad   (image_quad),
        .conv_data    (conv_data),
        .feed         (feed)
    );

    residue_writeback u_wb (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .result_valid (result_valid),
        .result_data  (result_data),
        .res_rd_addr  (res_rd_addr),
        .res_rd_data  (res_rd_data)
    );

endmodule

//--- design/residue_bank.sv
////////////////////
// Byte-wide dual-port residue memory
////////////////////
module residue_bank
    import cnn_feed_pkg::*;
#(
    parameter int DEPTH = 2 ** RES_ADDR_W
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [RES_ADDR_W-1:0] wr_addr,
    input  logic [RES_ADDR_W-1:0] rd_addr,
    input  pixel_t                wr_data,
    output pixel_t                rd_data
);

    pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr]; // Registered read
    end

endmodule

//--- design/residue_writeback.sv
////////////////////
// Stores result bytes round-robin over four residue banks
// Host reads one quad per address, one cycle later
////////////////////
module residue_writeback
    import cnn_feed_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  result_valid,
    input  pixel_t                result_data,
    input  logic [RES_ADDR_W-1:0] res_rd_addr,
    output quad_t                 res_rd_data
);

    logic [1:0]            bank_sel;
    logic [RES_ADDR_W-1:0] store_addr;
    logic [3:0]            bank_we;   // One-hot, one cycle after result_valid
    logic [RES_ADDR_W-1:0] wr_addr_q;
    pixel_t                wr_data_q;
    pixel_t                bank_q [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_sel   <= '0;
            store_addr <= '0;
            bank_we    <= '0;
        end else begin
            bank_we <= result_valid ? (4'b0001 << bank_sel) : 4'b0000;
            if (start) begin
                bank_sel   <= '0;
                store_addr <= '0;
            end else if (result_valid) begin
                bank_sel <= bank_sel + 2'd1;
                if (bank_sel == 2'd3)
                    store_addr <= store_addr + 1'b1; // Row of four filled
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q <= store_addr;
        wr_data_q <= result_data;
    end

    for (genvar b = 0; b < 4; b++) begin : g_bank
        residue_bank #(
            .DEPTH(2 ** RES_ADDR_W)
        ) u_bank (
            .clk     (clk),
            .wr_en   (bank_we[b]),
            .wr_addr (wr_addr_q),
            .rd_addr (res_rd_addr),
            .wr_data (wr_data_q),
            .rd_data (bank_q[b])
        );
    end

    assign res_rd_data.lane0 = bank_q[0];
    assign res_rd_data.lane1 = bank_q[1];
    assign res_rd_data.lane2 = bank_q[2];
    assign res_rd_data.lane3 = bank_q[3];

endmodule

//--- design/tile_window.sv
////////////////////
// Holds the current 4x4 tile and registers one feed beat per cycle
////////////////////
module tile_window
    import cnn_feed_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] step,
    input  logic [1:0] quad_slot,
    input  logic       block_active,
    input  quad_t      image_quad,
    input  pixel_t     conv_data,
    output feed_beat_t feed
);

    quad_t      tile_q [4]; // z-order quads of the tile
    pixel_t     pix [16];   // Same pixels, row-major
    logic [3:0] step_d;
    logic [1:0] slot_d;
    logic       active_d;
    logic [3:0] tap;
    logic [1:0] tap_row, tap_col;
    logic [1:0] row_n, col_n;
    feed_beat_t beat;

    function automatic pixel_t lane_of(input quad_t q, input logic [1:0] n);
        case (n)
            2'd0:    return q.lane0;
            2'd1:    return q.lane1;
            2'd2:    return q.lane2;
            default: return q.lane3;
        endcase
    endfunction

    // Memory data returns one cycle after the address
    always_ff @(posedge clk) begin
        if (reset) begin
            step_d   <= '0;
            slot_d   <= '0;
            active_d <= 1'b0;
        end else begin
            step_d   <= step;
            slot_d   <= quad_slot;
            active_d <= block_active;
        end
    end

    always_ff @(posedge clk) begin
        if (active_d && step_d < 4'd4)
            tile_q[slot_d] <= image_quad;
    end

    // Pixel (r, c) lives in quad {r[1], c[1]}, lane {r[0], c[0]}
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                pix[r * 4 + c] = lane_of(tile_q[(r / 2) * 2 + c / 2], 2'((r % 2) * 2 + c % 2));
            end
        end
    end

    // Weight k = 3r + c is used in step k+1
    assign tap     = step_d - 4'd1;
    assign tap_row = 2'(tap / 4'd3);
    assign tap_col = 2'(tap % 4'd3);
    assign row_n   = tap_row + 2'd1;
    assign col_n   = tap_col + 2'd1;

    always_comb begin
        beat = '0;
        if (active_d) begin
            beat.valid = 1'b1;
            beat.step  = step_d;
            beat.param = conv_data;
            if (step_d == 4'd0) begin
                beat.kind        = BEAT_HEADER;
                beat.lanes.lane1 = pixel_t'(TAPS); // MAC count
            end else if (step_d == 4'(STEPS_PER_BLOCK - 1)) begin
                beat.kind        = BEAT_SSFR;
                beat.lanes.lane0 = SSFR_OP;
                beat.param       = SSFR_ARG;
            end else begin
                beat.kind        = BEAT_PATCH;
                beat.lanes.lane0 = pix[{tap_row, tap_col}];
                beat.lanes.lane1 = pix[{tap_row, col_n}];
                beat.lanes.lane2 = pix[{row_n, tap_col}];
                beat.lanes.lane3 = pix[{row_n, col_n}];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            feed <= '0;
        else
            feed <= beat;
    end

endmodule

//--- files.f
design/cnn_feed_pkg.sv
design/residue_bank.sv
design/residue_writeback.sv
design/block_scheduler.sv
design/tile_window.sv
design/conv_feeder_top.sv
sim/tb_conv_feeder.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the feed sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f \
    --top-module tb_conv_feeder \
    --Mdir obj_dir -o tb_conv_feeder
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_conv_feeder > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\* PASS \*\*" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/feed_trace.txt
# I quad_address lane0 lane1 lane2 lane3, P param_address byte, R result byte
# All values hex, quads row-major on a grid four quads wide
I 000 3a 7c 15 e2
I 001 94 0b 6f d1
I 002 28 b3 c7 5e
I 003 81 4d f0 19
I 004 66 a2 3e 07
I 005 d9 52 8b 2c
I 006 1f e8 74 a0
I 007 bc 35 09 6a
I 008 47 f3 c2 88
I 009 0e 9d 61 b5
I 00a 73 2a de 50
I 00b e6 18 af 3c
I 00c 5b c9 04 97
I 00d a8 63 fd 21
I 00e 32 8e 4a ce
I 00f f5 17 b9 6d
P 000 12
P 001 05
P 002 fd
P 003 3b
P 004 7e
P 005 01
P 006 c4
P 007 28
P 008 99
P 009 60
P 00a a7
P 00b 44
P 00c 1c
P 00d e9
P 00e 02
P 00f b6
P 010 73
P 011 5d
P 012 8f
P 013 30
R 9c
R 41
R e7
R 08
R 5a
R d3
R 26
R bf

//--- sim/tb_conv_feeder.sv
////////////////////
// Testbench for the feed sequencer, driven from sim/feed_trace.txt
// Models both external memories and checks beats and residue readback
////////////////////
module tb_conv_feeder
    import cnn_feed_pkg::*;
();

    localparam int TILE_ROWS   = 2;
    localparam int TILE_COLS   = 2;
    localparam int NUM_FILTERS = 2;
    localparam int PERIOD      = 4;
    localparam int TILES       = TILE_ROWS * TILE_COLS;
    localparam int TOTAL_BEATS = NUM_FILTERS * TILES * STEPS_PER_BLOCK;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   start;
    logic [IMG_ADDR_W-1:0]  image_addr;
    quad_t                  image_quad = '0;
    logic [CONV_ADDR_W-1:0] conv_addr;
    pixel_t                 conv_data = '0;
    logic                   result_valid;
    pixel_t                 result_data;
    logic [RES_ADDR_W-1:0]  res_rd_addr;
    quad_t                  res_rd_data;
    feed_beat_t             feed;
    logic                   busy;

    quad_t                  img_mem [1 << IMG_ADDR_W];
    pixel_t                 conv_mem [1 << CONV_ADDR_W];
    logic [IMG_ADDR_W-1:0]  img_addr_q;
    logic [CONV_ADDR_W-1:0] conv_addr_q;
    pixel_t                 results [$];
    feed_beat_t             exp_beat;
    int                     beat_idx = 0;
    bit                     checking = 1'b0;
    bit                     trace_loaded = 1'b0;
    int                     seed = 32'hdfa5c597;

    always #(PERIOD / 2) clk = ~clk;

    conv_feeder_top #(
        .TILE_ROWS   (TILE_ROWS),
        .TILE_COLS   (TILE_COLS),
        .NUM_FILTERS (NUM_FILTERS)
    ) dut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .image_addr   (image_addr),
        .image_quad   (image_quad),
        .conv_addr    (conv_addr),
        .conv_data    (conv_data),
        .result_valid (result_valid),
        .result_data  (result_data),
        .res_rd_addr  (res_rd_addr),
        .res_rd_data  (res_rd_data),
        .feed         (feed),
        .busy         (busy)
    );

    task automatic flag_mismatch(input string name, input logic [63:0] want,
                                 input logic [63:0] got);
        $display("Fail %0t %s expected %h actual %h", $time, name, want, got);
        $display("** FAIL **");
        $fatal(1, "mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    function automatic pixel_t lane_pick(input quad_t q, input int n);
        case (n)
            0:       return q.lane0;
            1:       return q.lane1;
            2:       return q.lane2;
            default: return q.lane3;
        endcase
    endfunction

    // Tile pixel (r, c) of tile (tr, tc) from the quad grid layout
    function automatic pixel_t tile_pixel(input int tr, input int tc, input int r, input int c);
        int row;
        int col;
        row = 2 * tr + r / 2;
        col = 2 * tc + c / 2;
        return lane_pick(img_mem[IMG_ADDR_W'(row * 2 * TILE_COLS + col)], (r % 2) * 2 + c % 2);
    endfunction

    function automatic feed_beat_t expected_beat(input int idx);
        int         blk, s, f, tr, tc, k, r, c;
        feed_beat_t b;
        blk = idx / STEPS_PER_BLOCK;
        s   = idx % STEPS_PER_BLOCK;
        f   = blk / TILES;      // Filter outermost
        tr  = (blk % TILES) / TILE_COLS;
        tc  = (blk % TILES) % TILE_COLS;
        b       = '0;
        b.valid = 1'b1;
        b.step  = 4'(s);
        b.param = conv_mem[CONV_ADDR_W'(f * PARAMS_PER_FILTER + s)];
        if (s == 0) begin
            b.kind        = BEAT_HEADER;
            b.lanes.lane1 = pixel_t'(TAPS);
        end else if (s == STEPS_PER_BLOCK - 1) begin
            b.kind        = BEAT_SSFR;
            b.lanes.lane0 = SSFR_OP;
            b.param       = SSFR_ARG;
        end else begin
            k = s - 1;          // Weight k sits at parameter k+1
            r = k / 3;
            c = k % 3;
            b.kind        = BEAT_PATCH;
            b.lanes.lane0 = tile_pixel(tr, tc, r, c);
            b.lanes.lane1 = tile_pixel(tr, tc, r, c + 1);
            b.lanes.lane2 = tile_pixel(tr, tc, r + 1, c);
            b.lanes.lane3 = tile_pixel(tr, tc, r + 1, c + 1);
        end
        return b;
    endfunction

    task automatic load_trace();
        int                     fd, code;
        logic [7:0]             tag, b0, b1, b2, b3;
        logic [IMG_ADDR_W-1:0]  iaddr;
        logic [CONV_ADDR_W-1:0] paddr;
        string                  line;
        foreach (img_mem[i])
            img_mem[i] = '0;
        foreach (conv_mem[i])
            conv_mem[i] = '0;
        fd = $fopen("sim/feed_trace.txt", "r");
        if (fd == 0)
            abort_run("cannot open the trace file sim/feed_trace.txt");
        code = $fscanf(fd, " %c", tag);
        while (code == 1) begin
            case (tag)
                "#": code = $fgets(line, fd);
                "I": begin
                    code = $fscanf(fd, "%h %h %h %h %h", iaddr, b0, b1, b2, b3);
                    img_mem[iaddr] = {b0, b1, b2, b3}; // lane0 first
                end
                "P": begin
                    code = $fscanf(fd, "%h %h", paddr, b0);
                    conv_mem[paddr] = b0;
                end
                "R": begin
                    code = $fscanf(fd, "%h", b0);
                    results.push_back(b0);
                end
                default: abort_run("unknown line tag in the trace file");
            endcase
            code = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
    endtask

    // External memories answer one cycle after the address
    always @(posedge clk) begin
        img_addr_q  <= image_addr;
        conv_addr_q <= conv_addr;
    end

    always @(negedge clk) begin
        image_quad <= img_mem[img_addr_q];
        conv_data  <= conv_mem[conv_addr_q];
    end

    // Feed is stable at the falling edge
    always @(negedge clk) begin
        if (checking && feed.valid) begin
            assert (busy) else abort_run("feed beat seen while busy is low");
            assert (beat_idx < TOTAL_BEATS) else abort_run("more beats than planned");
            exp_beat = expected_beat(beat_idx);
            assert (feed == exp_beat) else flag_mismatch("feed", 64'(exp_beat), 64'(feed));
            beat_idx++;
        end else if (checking && beat_idx > 0 && beat_idx < TOTAL_BEATS) begin
            abort_run("gap in the beat stream before the last beat");
        end else if (!checking && !reset) begin
            assert (!busy && !feed.valid) else abort_run("busy or feed valid while idle");
        end
    end

    task automatic run_feed(input bit mid_start);
        beat_idx = 0;
        checking = 1'b1;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (busy) else abort_run("busy did not rise one cycle after start");
        @(negedge clk);
        assert (!feed.valid) else abort_run("first beat came too early");
        @(negedge clk);
        assert (feed.valid) else abort_run("first beat not two cycles after busy rose");
        if (mid_start) begin
            while (beat_idx < TOTAL_BEATS / 2)
                @(posedge clk);
            @(negedge clk);
            start = 1'b1; // Ignored while busy
            @(negedge clk);
            start = 1'b0;
        end
        while (beat_idx < TOTAL_BEATS)
            @(posedge clk);
        @(negedge clk);
        assert (!busy) else abort_run("busy did not fall after the last beat");
        checking = 1'b0;
    endtask

    task automatic send_results();
        int gap;
        foreach (results[i]) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
            result_valid = 1'b1;
            result_data  = results[i];
            @(negedge clk);
            result_valid = 1'b0;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic read_back();
        quad_t got;
        for (int a = 0; a < (results.size() + 3) / 4; a++) begin
            res_rd_addr = RES_ADDR_W'(a);
            @(negedge clk);
            got = res_rd_data;
            for (int n = 0; n < 4; n++) begin
                if (4 * a + n < results.size())
                    assert (lane_pick(got, n) == results[4 * a + n])
                        else flag_mismatch($sformatf("res_rd_data.lane%0d", n),
                                           64'(results[4 * a + n]), 64'(lane_pick(got, n)));
            end
        end
    endtask

    // Watchdog allows twice the planned cycles of both runs, writebacks and readback
    initial begin
        int planned;
        wait (trace_loaded);
        planned = 20 + 2 * (TOTAL_BEATS + 8) + 5 * results.size() + results.size() / 2 + 2;
        #(2 * planned * PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", 2 * planned);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset        = 1'b1;
        start        = 1'b0;
        result_valid = 1'b0;
        result_data  = '0;
        res_rd_addr  = '0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk); // Idle checks run in the beat checker
        run_feed(1'b1);
        send_results();
        read_back();
        repeat (3) @(negedge clk);
        run_feed(1'b0);
        repeat (2) @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule
